//--- hdl/accel_cfg_pkg.sv
package accel_cfg_pkg;

    ////////////////////////////////////////
    // Memory and pixel sizes
    ////////////////////////////////////////

    // One pixel per RAM word
    localparam int pixel_width = 16;

    // Words per line-buffer bank
    localparam int bram_depth = 1024;
    localparam int addr_width = $clog2(bram_depth);

    // Top address bit picks the half, the rest is the column
    localparam int col_width = addr_width - 1;

    ////////////////////////////////////////
    // Basic data types
    ////////////////////////////////////////

    typedef logic [pixel_width-1:0] pixel_t;

    typedef logic [col_width-1:0] col_t;

    // Rows use the same index width as columns
    typedef logic [col_width-1:0] row_t;

    // Bank address, half select above the column
    typedef struct packed {
        logic half;
        col_t col;
    } bram_addr_t;

endpackage

//--- hdl/rowbuf_pkg.sv
package rowbuf_pkg;

    ////////////////////////////////////////
    // Layer controller state
    ////////////////////////////////////////

    // One-hot, as driven by the layer controller
    typedef enum logic [4:0] {
        st_idle         = 5'b00001,
        st_prime_buffer = 5'b00010,
        st_wait_load    = 5'b00100,
        st_active       = 5'b01000,
        st_job_done     = 5'b10000
    } layer_state_e;

    ////////////////////////////////////////
    // Row-buffer channels
    ////////////////////////////////////////

    // Fill beat for both engines at once
    typedef struct packed {
        accel_cfg_pkg::row_t   row;
        accel_cfg_pkg::col_t   col;
        accel_cfg_pkg::pixel_t ce1_pixel;
        accel_cfg_pkg::pixel_t ce0_pixel;
    } fill_beat_t;

    // Fill command as seen by a single engine
    typedef struct packed {
        accel_cfg_pkg::row_t   row;
        accel_cfg_pkg::col_t   col;
        accel_cfg_pkg::pixel_t pixel;
    } fill_cmd_t;

    // Sequencer read word, one half bit per bank
    typedef struct packed {
        logic                even_half;
        logic                odd_half;
        accel_cfg_pkg::col_t col;
    } seq_word_t;

    // Engine output, odd bank on top
    typedef struct packed {
        accel_cfg_pkg::pixel_t odd_pixel;
        accel_cfg_pkg::pixel_t even_pixel;
    } pixel_pair_t;

    // Rows held by the line buffers
    localparam int prime_rows = 3;

    // Read acceptance to engine 0 output
    localparam int read_latency = 3;

endpackage

//--- hdl/delay_line.sv
module delay_line #(
    parameter int width = 1,
    parameter int depth = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [width-1:0] din,
    output logic [width-1:0] dout
);

    logic [width-1:0] stage [depth];

    // Shift chain, stage 0 takes the input
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < depth; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[depth-1];

endmodule

//--- hdl/rowbuf_ram.sv
module rowbuf_ram (
    input  logic                      clk,
    input  logic                      wr_en,
    input  accel_cfg_pkg::bram_addr_t wr_addr,
    input  accel_cfg_pkg::pixel_t     wr_data,
    input  logic                      rd_en,
    input  accel_cfg_pkg::bram_addr_t rd_addr,
    output accel_cfg_pkg::pixel_t     rd_data
);

    import accel_cfg_pkg::*;

    pixel_t mem [bram_depth];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////

    // Output register holds its word between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- hdl/rowbuf_engine.sv
module rowbuf_engine (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fill_en,
    input  rowbuf_pkg::fill_cmd_t   fill_cmd,
    input  logic                    rd_en,
    input  rowbuf_pkg::seq_word_t   rd_word,
    output logic                    out_valid,
    output rowbuf_pkg::pixel_pair_t out_pair
);

    import accel_cfg_pkg::*;
    import rowbuf_pkg::*;

    // Fill decode
    logic       row_kept;
    logic       even_hit;
    logic       odd_hit;
    logic       fill_half;

    // Registered write port, shared address and data
    logic       even_wr_en;
    logic       odd_wr_en;
    bram_addr_t wr_addr;
    pixel_t     wr_data;

    // Registered read port
    logic       rd_issue;
    bram_addr_t even_rd_addr;
    bram_addr_t odd_rd_addr;
    pixel_t     even_rd_data;
    pixel_t     odd_rd_data;

    ////////////////////////////////////////
    // Fill routing
    ////////////////////////////////////////

    // Rows past the held window are dropped
    assign row_kept = fill_en && (fill_cmd.row < row_t'(prime_rows));

    // Row 0 lands in both banks, row 1 odd only, row 2 even only
    assign even_hit = row_kept && (fill_cmd.row != row_t'(1));
    assign odd_hit  = row_kept && (fill_cmd.row != row_t'(2));

    // Row 0 uses half 0, rows 1 and 2 use half 1
    assign fill_half = (fill_cmd.row != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            even_wr_en <= 1'b0;
            odd_wr_en  <= 1'b0;
        end else begin
            even_wr_en <= even_hit;
            odd_wr_en  <= odd_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (row_kept) begin
            wr_addr <= '{half: fill_half, col: fill_cmd.col};
            wr_data <= fill_cmd.pixel;
        end
    end

    ////////////////////////////////////////
    // Read issue
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_issue <= 1'b0;
        end else begin
            rd_issue <= rd_en;
        end
    end

    // Each bank reads its own half of the same column
    always_ff @(posedge clk) begin
        if (rd_en) begin
            even_rd_addr <= '{half: rd_word.even_half, col: rd_word.col};
            odd_rd_addr  <= '{half: rd_word.odd_half, col: rd_word.col};
        end
    end

    ////////////////////////////////////////
    // Bank pair
    ////////////////////////////////////////

    rowbuf_ram u_even_bank (
        .clk     (clk),
        .wr_en   (even_wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_issue),
        .rd_addr (even_rd_addr),
        .rd_data (even_rd_data)
    );

    rowbuf_ram u_odd_bank (
        .clk     (clk),
        .wr_en   (odd_wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_issue),
        .rd_addr (odd_rd_addr),
        .rd_data (odd_rd_data)
    );

    ////////////////////////////////////////
    // Output pipeline
    ////////////////////////////////////////

    // Issue register counts as the first latency stage
    delay_line #(
        .width (1),
        .depth (read_latency - 1)
    ) u_valid_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (rd_issue),
        .dout (out_valid)
    );

    // Pair register runs free, qualified by out_valid
    always_ff @(posedge clk) begin
        out_pair <= '{odd_pixel: odd_rd_data, even_pixel: even_rd_data};
    end

endmodule

//--- hdl/awe_rowbuffers.sv
module awe_rowbuffers (
    input  logic                      clk,
    input  logic                      rst,
    input  rowbuf_pkg::layer_state_e  layer_state,
    input  accel_cfg_pkg::col_t       num_input_cols,
    input  logic                      fill_valid,
    output logic                      fill_ready,
    input  rowbuf_pkg::fill_beat_t    fill,
    input  logic                      rd_valid,
    output logic                      rd_ready,
    input  rowbuf_pkg::seq_word_t     rd_req,
    output logic                      ce0_out_valid,
    output logic                      ce1_out_valid,
    output rowbuf_pkg::pixel_pair_t   ce0_out,
    output rowbuf_pkg::pixel_pair_t   ce1_out
);

    import rowbuf_pkg::*;

    // Read request with its strobe, as carried to each engine
    typedef struct packed {
        logic      valid;
        seq_word_t word;
    } rd_slot_t;

    logic      fill_fire;
    logic      rd_fire;

    logic      fill_wr_en;
    fill_cmd_t ce0_fill_cmd;
    fill_cmd_t ce1_fill_cmd;

    rd_slot_t  ce0_rd;
    rd_slot_t  ce1_rd;

    ////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////

    // Fill only while priming, reads only while active
    assign fill_ready = (layer_state == st_prime_buffer);
    assign rd_ready   = (layer_state == st_active);

    assign fill_fire = fill_valid && fill_ready;
    assign rd_fire   = rd_valid && rd_ready;

    ////////////////////////////////////////
    // Fill input register
    ////////////////////////////////////////

    // Beats beyond the configured width never reach the banks
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_wr_en <= 1'b0;
        end else begin
            fill_wr_en <= fill_fire && (fill.col <= num_input_cols);
        end
    end

    // Split the beat, each engine gets its own pixel
    always_ff @(posedge clk) begin
        if (fill_fire) begin
            ce0_fill_cmd <= '{row: fill.row, col: fill.col, pixel: fill.ce0_pixel};
            ce1_fill_cmd <= '{row: fill.row, col: fill.col, pixel: fill.ce1_pixel};
        end
    end

    ////////////////////////////////////////
    // Read distribution
    ////////////////////////////////////////

    assign ce0_rd = '{valid: rd_fire, word: rd_req};

    // Engine 1 trails engine 0 by one cycle
    delay_line #(
        .width ($bits(rd_slot_t)),
        .depth (1)
    ) u_ce1_rd_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (ce0_rd),
        .dout (ce1_rd)
    );

    ////////////////////////////////////////
    // Convolution engines
    ////////////////////////////////////////

    rowbuf_engine u_ce0 (
        .clk       (clk),
        .rst       (rst),
        .fill_en   (fill_wr_en),
        .fill_cmd  (ce0_fill_cmd),
        .rd_en     (ce0_rd.valid),
        .rd_word   (ce0_rd.word),
        .out_valid (ce0_out_valid),
        .out_pair  (ce0_out)
    );

    rowbuf_engine u_ce1 (
        .clk       (clk),
        .rst       (rst),
        .fill_en   (fill_wr_en),
        .fill_cmd  (ce1_fill_cmd),
        .rd_en     (ce1_rd.valid),
        .rd_word   (ce1_rd.word),
        .out_valid (ce1_out_valid),
        .out_pair  (ce1_out)
    );

endmodule

//--- dv/rowbuf_assertions.sv
module rowbuf_assertions (
    input logic                     clk,
    input logic                     rst,
    input rowbuf_pkg::layer_state_e layer_state,
    input logic                     fill_ready,
    input logic                     rd_valid,
    input logic                     rd_ready,
    input logic                     ce0_out_valid,
    input logic                     ce1_out_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    import rowbuf_pkg::*;

    // Failed property count
    int assert_errors = 0;

    ////////////////////////////////////////
    // Handshake readiness
    ////////////////////////////////////////

    // Readies follow the controller state, reset or not
    fill_ready_state: assert property (@(posedge clk)
        fill_ready |-> layer_state == st_prime_buffer)
        else begin
            assert_errors++;
            $error("fill_ready high outside the prime-buffer state");
        end

    rd_ready_state: assert property (@(posedge clk)
        rd_ready |-> layer_state == st_active)
        else begin
            assert_errors++;
            $error("rd_ready high outside the active state");
        end

    ////////////////////////////////////////
    // Output timing
    ////////////////////////////////////////

    ce1_trails_ce0: assert property (@(posedge clk) disable iff (rst)
        ce1_out_valid == $past(ce0_out_valid))
        else begin
            assert_errors++;
            $error("ce1_out_valid does not trail ce0_out_valid by one cycle");
        end

    read_to_ce0: assert property (@(posedge clk) disable iff (rst)
        (rd_valid && rd_ready) |-> ##read_latency ce0_out_valid)
        else begin
            assert_errors++;
            $error("Accepted read without ce0 output at the read latency");
        end

    ce0_from_read: assert property (@(posedge clk) disable iff (rst)
        ce0_out_valid |-> $past(rd_valid && rd_ready, read_latency))
        else begin
            assert_errors++;
            $error("ce0 output without a read accepted at the read latency");
        end

    // First reset edge clears the pipeline
    quiet_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (!ce0_out_valid && !ce1_out_valid))
        else begin
            assert_errors++;
            $error("Output valid high during reset");
        end

endmodule

bind awe_rowbuffers rowbuf_assertions u_assertions (
    .clk           (clk),
    .rst           (rst),
    .layer_state   (layer_state),
    .fill_ready    (fill_ready),
    .rd_valid      (rd_valid),
    .rd_ready      (rd_ready),
    .ce0_out_valid (ce0_out_valid),
    .ce1_out_valid (ce1_out_valid)
);

//--- dv/rowbuf_tb.sv
module rowbuf_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import accel_cfg_pkg::*;
    import rowbuf_pkg::*;

    localparam int n_read     = 600;
    localparam int n_fill2    = 400;
    localparam int n_gate     = 24;
    localparam int n_beats    = prime_rows * (1 << col_width) + n_fill2 + n_gate;
    localparam int n_reads    = 2 * n_read + n_gate;
    localparam int timeout_ns = (n_beats + n_reads + 200) * 40;

    // Expected pair and the cycle count at which it must show up
    typedef struct packed {
        pixel_pair_t pair;
        logic [31:0] due;
    } expect_t;

    logic         clk = 1'b0;
    logic         rst;
    layer_state_e layer_state;
    col_t         num_input_cols;
    logic         fill_valid;
    logic         fill_ready;
    fill_beat_t   fill;
    logic         rd_valid;
    logic         rd_ready;
    seq_word_t    rd_req;
    logic         ce0_out_valid;
    logic         ce1_out_valid;
    pixel_pair_t  ce0_out;
    pixel_pair_t  ce1_out;

    // Bank index is engine times two, plus one for the odd bank
    pixel_t       bank_mem [4][bram_depth];
    expect_t      exp_q [2][$];
    logic [31:0]  cyc = '0;
    int           value_errors = 0;
    int           protocol_errors = 0;

    awe_rowbuffers uut (
        .clk            (clk),
        .rst            (rst),
        .layer_state    (layer_state),
        .num_input_cols (num_input_cols),
        .fill_valid     (fill_valid),
        .fill_ready     (fill_ready),
        .fill           (fill),
        .rd_valid       (rd_valid),
        .rd_ready       (rd_ready),
        .rd_req         (rd_req),
        .ce0_out_valid  (ce0_out_valid),
        .ce1_out_valid  (ce1_out_valid),
        .ce0_out        (ce0_out),
        .ce1_out        (ce1_out)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    task automatic store_beat(input fill_beat_t beat);
        pixel_t px [2];
        px[0] = beat.ce0_pixel;
        px[1] = beat.ce1_pixel;
        if (beat.col <= num_input_cols) begin
            for (int e = 0; e < 2; e++) begin
                case (beat.row)
                    row_t'(0): begin
                        bank_mem[2*e][{1'b0, beat.col}]   = px[e];
                        bank_mem[2*e+1][{1'b0, beat.col}] = px[e];
                    end
                    row_t'(1): bank_mem[2*e+1][{1'b1, beat.col}] = px[e];
                    row_t'(2): bank_mem[2*e][{1'b1, beat.col}]   = px[e];
                    default: ;
                endcase
            end
        end
    endtask

    function automatic pixel_pair_t expected_pair(input int eng, input seq_word_t word);
        pixel_pair_t pair;
        pair.odd_pixel  = bank_mem[2*eng+1][{word.odd_half, word.col}];
        pair.even_pixel = bank_mem[2*eng][{word.even_half, word.col}];
        return pair;
    endfunction

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    function automatic fill_beat_t random_beat();
        fill_beat_t beat;
        beat.row       = row_t'($urandom_range(8));
        beat.col       = col_t'($urandom);
        beat.ce0_pixel = pixel_t'($urandom);
        beat.ce1_pixel = pixel_t'($urandom);
        return beat;
    endfunction

    function automatic seq_word_t random_word();
        seq_word_t word;
        word.even_half = $urandom_range(1);
        word.odd_half  = $urandom_range(1);
        word.col       = col_t'($urandom);
        return word;
    endfunction

    function automatic layer_state_e random_state();
        case ($urandom_range(4))
            0: return st_idle;
            1: return st_prime_buffer;
            2: return st_wait_load;
            3: return st_active;
            default: return st_job_done;
        endcase
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic send_fill(input fill_beat_t beat);
        logic accept;
        repeat ($urandom_range(1)) @(negedge clk);
        fill_valid = 1'b1;
        fill       = beat;
        accept     = (layer_state == st_prime_buffer);
        @(posedge clk);
        check_bit("fill_ready", fill_ready, accept);
        if (accept) begin
            store_beat(beat);
        end
        @(negedge clk);
        fill_valid = 1'b0;
    endtask

    task automatic send_read(input seq_word_t word);
        logic        accept;
        logic [31:0] drive_cyc;
        expect_t     item;
        repeat ($urandom_range(1)) @(negedge clk);
        rd_valid  = 1'b1;
        rd_req    = word;
        accept    = (layer_state == st_active);
        drive_cyc = cyc;
        @(posedge clk);
        check_bit("rd_ready", rd_ready, accept);
        if (accept) begin
            // Engine 1 is one cycle behind engine 0
            for (int e = 0; e < 2; e++) begin
                item.pair = expected_pair(e, word);
                item.due  = drive_cyc + read_latency + e;
                exp_q[e].push_back(item);
            end
        end
        @(negedge clk);
        rd_valid = 1'b0;
    endtask

    task automatic drain_reads();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            @(negedge clk);
        end
        // Room for any stray output
        repeat (3) @(negedge clk);
    endtask

    ////////////////////////////////////////
    // Output checker
    ////////////////////////////////////////

    task automatic check_engine(input int eng, input logic vld, input pixel_pair_t got);
        expect_t head;
        if (vld) begin
            if (exp_q[eng].size() == 0) begin
                protocol_errors++;
                $display("Engine %0d gave an output with no read pending at cycle %0d", eng, cyc);
            end else begin
                head = exp_q[eng].pop_front();
                if (head.due != cyc) begin
                    protocol_errors++;
                    $display("Engine %0d output came at cycle %0d instead of cycle %0d",
                             eng, cyc, head.due);
                end
                if (got !== head.pair) begin
                    value_errors++;
                    $display("FAILED ce%0d_out: got %h, expected %h", eng, got, head.pair);
                end
            end
        end else if (exp_q[eng].size() != 0 && exp_q[eng][0].due <= cyc) begin
            protocol_errors++;
            $display("Engine %0d missed its output due at cycle %0d", eng, exp_q[eng][0].due);
            void'(exp_q[eng].pop_front());
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_engine(0, ce0_out_valid, ce0_out);
            check_engine(1, ce1_out_valid, ce1_out);
        end
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        void'($urandom(32'had095bc8));
        rst            = 1'b1;
        layer_state    = st_idle;
        num_input_cols = '0;
        fill_valid     = 1'b0;
        fill           = '0;
        rd_valid       = 1'b0;
        rd_req         = '0;

        // Quiet outputs through reset and just after
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (i == 15) begin
                rst = 1'b0;
            end
            check_bit("ce0_out_valid", ce0_out_valid, 1'b0);
            check_bit("ce1_out_valid", ce1_out_valid, 1'b0);
            check_bit("fill_ready", fill_ready, 1'b0);
            check_bit("rd_ready", rd_ready, 1'b0);
        end

        // Full prime of rows 0 to 2
        num_input_cols = '1;
        layer_state    = st_prime_buffer;
        for (int r = 0; r < prime_rows; r++) begin
            for (int c = 0; c < (1 << col_width); c++) begin
                send_fill('{row: row_t'(r), col: col_t'(c),
                            ce1_pixel: pixel_t'($urandom), ce0_pixel: pixel_t'($urandom)});
            end
        end
        repeat (3) @(negedge clk);
        layer_state = st_active;
        repeat (n_read) send_read(random_word());
        drain_reads();

        // Offers in random states, channels idle at each change
        for (int i = 0; i < n_gate; i++) begin
            layer_state = random_state();
            send_fill(random_beat());
            send_read(random_word());
            drain_reads();
        end

        // Second prime with a narrower layer and stray rows
        layer_state    = st_prime_buffer;
        num_input_cols = col_t'($urandom_range((1 << col_width) - 2));
        repeat (n_fill2) send_fill(random_beat());
        repeat (3) @(negedge clk);
        layer_state = st_active;
        repeat (n_read) send_read(random_word());
        drain_reads();
        layer_state = st_job_done;
        repeat (2) @(negedge clk);

        $display("Errors: %0d value, %0d protocol, %0d assertion",
                 value_errors, protocol_errors, uut.u_assertions.assert_errors);
        if (value_errors == 0 && protocol_errors == 0
                && uut.u_assertions.assert_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Run did not finish within %0d ns, errors: %0d value, %0d protocol",
                 timeout_ns, value_errors, protocol_errors);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- build.f
hdl/accel_cfg_pkg.sv
hdl/rowbuf_pkg.sv
hdl/delay_line.sv
hdl/rowbuf_ram.sv
hdl/rowbuf_engine.sv
hdl/awe_rowbuffers.sv
dv/rowbuf_assertions.sv
dv/rowbuf_tb.sv

//--- Bender.yml
package:
  name: awe_rowbuffers

sources:
  - files:
      - hdl/accel_cfg_pkg.sv
      - hdl/rowbuf_pkg.sv
      - hdl/delay_line.sv
      - hdl/rowbuf_ram.sv
      - hdl/rowbuf_engine.sv
      - hdl/awe_rowbuffers.sv
  - target: test
    files:
      - dv/rowbuf_assertions.sv
      - dv/rowbuf_tb.sv
